//--- bench/conv_layer_checks.svh
`ifndef CONV_LAYER_CHECKS_SVH
`define CONV_LAYER_CHECKS_SVH

// one output word against its expected value
task automatic check_word(
    input conv_fixed_pkg::word_t got,
    input conv_fixed_pkg::word_t exp,
    input int                    lane,
    input string                 what
);
    if (got !== exp) begin
        $display("MISMATCH at %0t: lane %0d %s, got %h expected %h",
                 $time, lane, what, got, exp);
        error_cnt++;
    end
endtask

// every lane is compared so all bad lanes show up, not just the first
task automatic check_out_vec(
    input conv_layer_pkg::out_vec_t got,
    input conv_layer_pkg::out_vec_t exp,
    input string                    what
);
    for (int j = 0; j < conv_layer_pkg::NUM_OUTPUTS; j++) begin
        check_word(got[j], exp[j], j, what);
    end
endtask

// levels of valid_o and ready_o at a falling edge
task automatic check_handshake(
    input logic  exp_valid,
    input logic  exp_ready,
    input string what
);
    if (valid_o !== exp_valid || ready_o !== exp_ready) begin
        $display("MISMATCH at %0t: %s, valid_o %b ready_o %b, expected %b %b",
                 $time, what, valid_o, ready_o, exp_valid, exp_ready);
        error_cnt++;
    end
endtask

`endif

//--- bench/conv_layer_tb.sv
module conv_layer_tb;

    localparam int MAX_TESTS = 16;
    // six tap weights followed by the bias
    localparam int NUM_CFG = conv_layer_pkg::NUM_TAPS + 1;
    // worst case input gaps, compute, yumi delay, plus slack
    localparam int CYCLES_PER_TEST = conv_layer_pkg::NUM_WORDS * 4 + 7 + 8 + 20;

    logic                         clk_i;
    logic                         rst_i;
    logic                         start_i;
    conv_layer_pkg::conv_cfg_wr_t cfg_i;
    logic                         valid_i;
    logic                         ready_o;
    conv_fixed_pkg::word_t        data_i;
    logic                         valid_o;
    logic                         yumi_i;
    conv_layer_pkg::out_vec_t     data_o;

    // records read from the data file
    logic [8*32-1:0]          test_name  [MAX_TESTS];
    logic                     test_stall [MAX_TESTS];
    conv_fixed_pkg::word_t    test_cfg   [MAX_TESTS][NUM_CFG];
    conv_fixed_pkg::word_t    test_in    [MAX_TESTS][conv_layer_pkg::NUM_WORDS];
    conv_layer_pkg::out_vec_t test_exp   [MAX_TESTS];

    int          num_tests   = 0;
    int          error_cnt   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    logic [15:0] lfsr_q;

    `include "conv_layer_checks.svh"

    conv_layer_top u_dut (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (start_i),
        .cfg_i   (cfg_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .data_i  (data_i),
        .valid_o (valid_o),
        .yumi_i  (yumi_i),
        .data_o  (data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // run guard whose limit is set once the records are known
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    // lines whose first token is # are column notes
    task automatic load_tests(output logic ok);
        int              fd;
        int              r;
        int              stall;
        logic [8*32-1:0] tok;
        logic [8*160-1:0] junk;
        logic [15:0]     w;
        fd = $fopen("bench/conv_testdata.txt", "r");
        ok = 1'b0;
        if (fd != 0) begin
            r = $fscanf(fd, "%s", tok);
            while (r == 1 && num_tests < MAX_TESTS) begin
                if (tok == "#") begin
                    r = $fgets(junk, fd);
                end else begin
                    test_name[num_tests] = tok;
                    r = $fscanf(fd, "%d", stall);
                    test_stall[num_tests] = (stall != 0);
                    for (int a = 0; a < NUM_CFG; a++) begin
                        r = $fscanf(fd, "%h", w);
                        test_cfg[num_tests][a] = w;
                    end
                    for (int n = 0; n < conv_layer_pkg::NUM_WORDS; n++) begin
                        r = $fscanf(fd, "%h", w);
                        test_in[num_tests][n] = w;
                    end
                    for (int j = 0; j < conv_layer_pkg::NUM_OUTPUTS; j++) begin
                        r = $fscanf(fd, "%h", w);
                        test_exp[num_tests][j] = w;
                    end
                    num_tests++;
                end
                r = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
            ok = (num_tests > 0);
        end
    endtask

    // config, start, load, compute latency, then hand the result off
    task automatic run_test(input int t);
        int                       gap;
        int                       delay;
        conv_layer_pkg::out_vec_t held;
        for (int a = 0; a < NUM_CFG; a++) begin
            @(negedge clk_i);
            cfg_i.we   = 1'b1;
            cfg_i.addr = conv_layer_pkg::cfg_addr_t'(a);
            cfg_i.data = test_cfg[t][a];
        end
        @(negedge clk_i);
        cfg_i = '0;
        check_handshake(1'b0, 1'b0, "idle before start");
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        check_handshake(1'b0, 1'b1, "after start");
        // ready_o holds high for the whole load phase
        for (int n = 0; n < conv_layer_pkg::NUM_WORDS; n++) begin
            gap = 0;
            if (test_stall[t]) begin
                take_bits(2, gap);
            end
            valid_i = 1'b0;
            repeat (gap) @(negedge clk_i);
            check_handshake(1'b0, 1'b1, "load phase");
            valid_i = 1'b1;
            data_i  = test_in[t][n];
            @(negedge clk_i);
        end
        valid_i = 1'b0;
        // six taps and the bias cycle pass with valid_o still low
        for (int k = 0; k < conv_layer_pkg::NUM_TAPS + 1; k++) begin
            check_handshake(1'b0, 1'b0, "compute phase");
            @(negedge clk_i);
        end
        check_handshake(1'b1, 1'b0, "result latency");
        check_out_vec(data_o, test_exp[t], "result");
        held  = data_o;
        delay = 0;
        if (test_stall[t]) begin
            take_bits(3, delay);
        end
        repeat (delay) begin
            @(negedge clk_i);
            check_handshake(1'b1, 1'b0, "waiting for yumi");
            check_out_vec(data_o, held, "held for yumi");
        end
        yumi_i = 1'b1;
        @(negedge clk_i);
        yumi_i = 1'b0;
        check_handshake(1'b0, 1'b0, "after yumi");
    endtask

    initial begin
        logic ok;
        int   pass_cnt;
        int   fail_cnt;
        int   errs_before;
        rst_i    = 1'b1;
        start_i  = 1'b0;
        cfg_i    = '0;
        valid_i  = 1'b0;
        data_i   = '0;
        yumi_i   = 1'b0;
        lfsr_q   = 16'd54843;
        pass_cnt = 0;
        fail_cnt = 0;
        load_tests(ok);
        if (!ok) begin
            $display("test data file missing or empty");
            $display("tests failed");
            $finish;
        end else begin
            cycle_limit = num_tests * CYCLES_PER_TEST;
            repeat (3) @(negedge clk_i);
            rst_i = 1'b0;
            check_handshake(1'b0, 1'b0, "after reset");
            check_out_vec(data_o, '0, "after reset");
            for (int t = 0; t < num_tests; t++) begin
                errs_before = error_cnt;
                run_test(t);
                if (error_cnt == errs_before) begin
                    pass_cnt++;
                    $display("%0s: PASS", test_name[t]);
                end else begin
                    fail_cnt++;
                    $display("%0s: FAIL with %0d errors", test_name[t],
                             error_cnt - errs_before);
                end
            end
            $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && error_cnt == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

//--- bench/conv_testdata.txt
# name stall w0 w1 w2 w3 w4 w5 bias (tap t is kernel row t/2, channel t%2), hex words
# next line 16 input words i0 q0 .. i7 q7, then a line of 6 expected outputs
basic_mixed 0 1000 f800 0400 2000 f000 0800 0100
0064 ffd8 ff38 003c 012c 0014 ffb0 ff88 002c 0010 0000 fed4 00fa 0064 fff0 0008
009c 00a1 00fa 0081 fe04 02b1
round_ties 0 0800 0000 0000 0000 0000 0000 ffff
0003 0011 fffd 0022 0001 0033 ffff 0044 0005 0055 fffb 0066 0007 0077 0009 0088
0001 fffe 0000 ffff 0002 fffd
basic_mixed_stall 1 1000 f800 0400 2000 f000 0800 0100
0064 ffd8 ff38 003c 012c 0014 ffb0 ff88 002c 0010 0000 fed4 00fa 0064 fff0 0008
009c 00a1 00fa 0081 fe04 02b1
sat_pos 0 4000 0000 0000 0000 0000 0000 1000
1000 7fff 1bff 8000 1c00 7fff 7fff 8000 f000 7fff 0400 8000 0100 7fff 0200 8000
5000 7ffc 7fff 7fff d000 2000
sat_neg 0 e000 e000 e000 e000 e000 e000 f800
0400 0400 0800 0800 0c00 0c00 1000 1000 0000 0000 fc00 fc00 f000 f000 4000 4000
9800 8000 8800 c800 4800 8000
sat_neg_stall 1 e000 e000 e000 e000 e000 e000 f800
0400 0400 0800 0800 0c00 0c00 1000 1000 0000 0000 fc00 fc00 f000 f000 4000 4000
9800 8000 8800 c800 4800 8000
round_ties_stall 1 0800 0000 0000 0000 0000 0000 ffff
0003 0011 fffd 0022 0001 0033 ffff 0044 0005 0055 fffb 0066 0007 0077 0009 0088
0001 fffe 0000 ffff 0002 fffd

//--- design/conv_coef_regs.sv
module conv_coef_regs (
    input  logic                        clk_i,
    input  logic                        rst_i,

    // config write port
    input  conv_layer_pkg::conv_cfg_wr_t cfg_i,
    input  logic                        busy_i,

    // read side, indexed by the current tap
    input  conv_layer_pkg::tap_idx_t    tap_i,
    output conv_fixed_pkg::word_t       weight_o,
    output conv_fixed_pkg::word_t       bias_o
);

    conv_fixed_pkg::word_t weight_q [conv_layer_pkg::NUM_TAPS];
    conv_fixed_pkg::word_t bias_q;

    logic wr_ok;

    // writes during a run are dropped
    assign wr_ok = cfg_i.we && !busy_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < conv_layer_pkg::NUM_TAPS; i++) begin
                weight_q[i] <= '0;
            end
            bias_q <= '0;
        end else if (wr_ok) begin
            // weights at 0..5, bias at 6, address 7 falls through
            if (int'(cfg_i.addr) < conv_layer_pkg::NUM_TAPS) begin
                weight_q[cfg_i.addr] <= cfg_i.data;
            end else if (cfg_i.addr == conv_layer_pkg::BIAS_ADDR) begin
                bias_q <= cfg_i.data;
            end
        end
    end

    // weight for the tap being processed this cycle
    // out of range taps read as zero so nothing undefined reaches the lanes
    always_comb begin
        if (int'(tap_i) < conv_layer_pkg::NUM_TAPS) begin
            weight_o = weight_q[tap_i];
        end else begin
            weight_o = '0;
        end
    end

    assign bias_o = bias_q;

    // coefficients must hold still for the whole run
    // busy comes from the controller, so this checks the driver of cfg_i against it
    a_no_write_when_busy : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(cfg_i.we && busy_i)
    ) else $error("config write while layer busy, write dropped");

endmodule

//--- design/conv_fixed_pkg.sv
package conv_fixed_pkg;

    // word format: signed Q4.12
    localparam int WORD_BITS = 16;
    localparam int FRAC_BITS = 12;

    // a Q4.12 times Q4.12 product is Q8.24
    localparam int PROD_BITS = 2 * WORD_BITS;

    // four guard bits above the product
    // six full-scale products plus bias and rounding still fit
    localparam int ACC_BITS = PROD_BITS + 4;

    // sample, weight, bias and output word
    typedef logic signed [WORD_BITS-1:0] word_t;

    // one raw product, Q8.24
    typedef logic signed [PROD_BITS-1:0] prod_t;

    // running sum of products, still with 2*FRAC_BITS fraction bits
    typedef logic signed [ACC_BITS-1:0] acc_t;

    // half an output LSB at accumulator scale
    // adding it before the arithmetic shift rounds half up, towards +inf
    localparam acc_t ROUND_HALF = acc_t'(1) <<< (FRAC_BITS - 1);

    // clamp limits of the output word
    localparam word_t WORD_MAX = {1'b0, {(WORD_BITS-1){1'b1}}};
    localparam word_t WORD_MIN = {1'b1, {(WORD_BITS-1){1'b0}}};

endpackage

//--- design/conv_input_buffer.sv
module conv_input_buffer (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // load side, one word per accepted transfer
    input  logic                      shift_en_i,
    input  conv_fixed_pkg::word_t     data_i,

    // read side, one operand per output lane
    input  conv_layer_pkg::tap_idx_t  tap_i,
    output conv_layer_pkg::out_vec_t  lane_data_o
);

    // word n holds sample n/2, channel n%2 once all words are in
    conv_fixed_pkg::word_t buf_q [conv_layer_pkg::NUM_WORDS];

    // new words enter at the top and walk down
    // after NUM_WORDS shifts the first word sits at index 0
    always_ff @(posedge clk_i) begin
        if (shift_en_i) begin
            for (int n = 0; n < conv_layer_pkg::NUM_WORDS - 1; n++) begin
                buf_q[n] <= buf_q[n+1];
            end
            buf_q[conv_layer_pkg::NUM_WORDS-1] <= data_i;
        end
    end

    // tap t picks kernel row k = t/2 and channel c = t%2
    // lane j then needs sample j+k, channel c
    always_comb begin
        int row;
        int chan;
        int idx;
        row  = int'(tap_i) / conv_layer_pkg::KERNEL_WIDTH;
        chan = int'(tap_i) % conv_layer_pkg::KERNEL_WIDTH;
        for (int j = 0; j < conv_layer_pkg::NUM_OUTPUTS; j++) begin
            idx = (j + row) * conv_layer_pkg::KERNEL_WIDTH + chan;
            // unused tap codes 6 and 7 would index past the end
            if (int'(tap_i) < conv_layer_pkg::NUM_TAPS) begin
                lane_data_o[j] = buf_q[idx];
            end else begin
                lane_data_o[j] = '0;
            end
        end
    end

    // an X shifted in here would poison every lane that reads that slot later
    a_data_known : assert property (
        @(posedge clk_i) disable iff (rst_i)
        shift_en_i |-> !$isunknown(data_i)
    ) else $error("unknown input word accepted into buffer");

endmodule

//--- design/conv_layer_ctrl.sv
module conv_layer_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_i,

    input  logic                       start_i,

    // input handshake
    input  logic                       valid_i,
    output logic                       ready_o,

    // output handshake
    input  logic                       yumi_i,
    output logic                       valid_o,

    // datapath control
    output logic                       buf_shift_en_o,
    output conv_layer_pkg::conv_step_t step_o,
    output logic                       busy_o
);

    conv_layer_pkg::state_t state_q;
    conv_layer_pkg::state_t state_d;

    // words received in SHIFT, current tap in COMPUTE
    conv_layer_pkg::cnt_t cnt_q;
    conv_layer_pkg::cnt_t cnt_d;

    logic accept;
    logic last_word;
    logic last_tap;

    assign accept    = valid_i && ready_o;
    assign last_word = accept && (int'(cnt_q) == conv_layer_pkg::NUM_WORDS - 1);
    assign last_tap  = int'(cnt_q) == conv_layer_pkg::NUM_TAPS - 1;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            conv_layer_pkg::READY: begin
                if (start_i) begin
                    state_d = conv_layer_pkg::SHIFT;
                end
            end
            conv_layer_pkg::SHIFT: begin
                // counter rolls back to zero, ready to count taps
                if (last_word) begin
                    state_d = conv_layer_pkg::COMPUTE;
                    cnt_d   = '0;
                end else if (accept) begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            conv_layer_pkg::COMPUTE: begin
                if (last_tap) begin
                    state_d = conv_layer_pkg::BIAS;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            conv_layer_pkg::BIAS: begin
                state_d = conv_layer_pkg::DONE;
            end
            conv_layer_pkg::DONE: begin
                // only back pressure can stretch this state
                if (yumi_i) begin
                    state_d = conv_layer_pkg::READY;
                end
            end
            default: begin
                state_d = conv_layer_pkg::READY;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= conv_layer_pkg::READY;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    assign ready_o        = state_q == conv_layer_pkg::SHIFT;
    assign valid_o        = state_q == conv_layer_pkg::DONE;
    assign busy_o         = state_q != conv_layer_pkg::READY;
    assign buf_shift_en_o = accept;

    // lanes see one tap per COMPUTE cycle, cleared on tap 0
    always_comb begin
        step_o.tap_en  = state_q == conv_layer_pkg::COMPUTE;
        step_o.clear   = step_o.tap_en && (cnt_q == '0);
        step_o.tap     = conv_layer_pkg::tap_idx_t'(cnt_q);
        step_o.bias_en = state_q == conv_layer_pkg::BIAS;
    end

    // result must not be withdrawn before the consumer takes it
    a_valid_held : assert property (
        @(posedge clk_i) disable iff (rst_i)
        valid_o && !yumi_i |=> valid_o
    ) else $error("valid_o dropped before yumi_i");

    a_yumi_needs_valid : assert property (
        @(posedge clk_i) disable iff (rst_i)
        yumi_i |-> valid_o
    ) else $error("yumi_i asserted without valid_o");

endmodule

//--- design/conv_layer_pkg.sv
package conv_layer_pkg;

    // samples per run, each sample carries an i and a q word
    localparam int LAYER_HEIGHT = 8;

    // kernel rows and channels
    localparam int KERNEL_HEIGHT = 3;
    localparam int KERNEL_WIDTH  = 2;

    // valid positions only, no padding and unit stride
    localparam int NUM_OUTPUTS = LAYER_HEIGHT - KERNEL_HEIGHT + 1;

    // one tap per kernel row and channel
    localparam int NUM_TAPS = KERNEL_HEIGHT * KERNEL_WIDTH;

    // words loaded per run
    localparam int NUM_WORDS = LAYER_HEIGHT * KERNEL_WIDTH;

    // shared word/tap counter in the controller
    localparam int CNT_BITS = $clog2(NUM_WORDS);

    // tap t means kernel row t/2 and channel t%2
    typedef logic [2:0] tap_idx_t;

    // 0..5 select the tap weights, 6 the bias, 7 is unused
    typedef logic [2:0] cfg_addr_t;

    localparam cfg_addr_t BIAS_ADDR = 3'd6;

    typedef logic [CNT_BITS-1:0] cnt_t;

    // config write port, only honoured while the layer is idle
    typedef struct packed {
        logic                  we;
        cfg_addr_t             addr;
        conv_fixed_pkg::word_t data;
    } conv_cfg_wr_t;

    // per-cycle command from the controller to every lane
    typedef struct packed {
        logic     clear;
        logic     tap_en;
        tap_idx_t tap;
        logic     bias_en;
    } conv_step_t;

    // one word per output lane
    typedef conv_fixed_pkg::word_t [NUM_OUTPUTS-1:0] out_vec_t;

    typedef enum logic [2:0] {
        READY,
        SHIFT,
        COMPUTE,
        BIAS,
        DONE
    } state_t;

endpackage

//--- design/conv_layer_top.sv
module conv_layer_top (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         start_i,

    // coefficient writes, idle only
    input  conv_layer_pkg::conv_cfg_wr_t cfg_i,

    // input words, valid/ready
    input  logic                         valid_i,
    output logic                         ready_o,
    input  conv_fixed_pkg::word_t        data_i,

    // output vector, valid/yumi
    output logic                         valid_o,
    input  logic                         yumi_i,
    output conv_layer_pkg::out_vec_t     data_o
);

    logic                       buf_shift_en;
    logic                       busy;
    conv_layer_pkg::conv_step_t step;
    conv_fixed_pkg::word_t      weight;
    conv_fixed_pkg::word_t      bias;
    conv_layer_pkg::out_vec_t   lane_data;

    conv_layer_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .valid_i        (valid_i),
        .ready_o        (ready_o),
        .yumi_i         (yumi_i),
        .valid_o        (valid_o),
        .buf_shift_en_o (buf_shift_en),
        .step_o         (step),
        .busy_o         (busy)
    );

    // one weight per cycle, broadcast to every lane
    conv_coef_regs u_coef (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .cfg_i    (cfg_i),
        .busy_i   (busy),
        .tap_i    (step.tap),
        .weight_o (weight),
        .bias_o   (bias)
    );

    conv_input_buffer u_buf (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .shift_en_i  (buf_shift_en),
        .data_i      (data_i),
        .tap_i       (step.tap),
        .lane_data_o (lane_data)
    );

    // all output positions run in lockstep
    for (genvar j = 0; j < conv_layer_pkg::NUM_OUTPUTS; j++) begin : g_lane
        conv_mac_lane u_lane (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .step_i   (step),
            .sample_i (lane_data[j]),
            .weight_i (weight),
            .bias_i   (bias),
            .result_o (data_o[j])
        );
    end

endmodule

//--- design/conv_mac_lane.sv
module conv_mac_lane (
    input  logic                       clk_i,
    input  logic                       rst_i,

    // command from the controller
    input  conv_layer_pkg::conv_step_t step_i,

    // operands for this cycle
    input  conv_fixed_pkg::word_t      sample_i,
    input  conv_fixed_pkg::word_t      weight_i,
    input  conv_fixed_pkg::word_t      bias_i,

    output conv_fixed_pkg::word_t      result_o
);

    conv_fixed_pkg::prod_t product;
    conv_fixed_pkg::acc_t  acc_q;
    conv_fixed_pkg::acc_t  biased;
    conv_fixed_pkg::acc_t  scaled;
    conv_fixed_pkg::word_t sat;
    conv_fixed_pkg::word_t result_q;

    // full precision Q8.24 product, operands sign extended
    assign product = sample_i * weight_i;

    // first tap of a run overwrites, the rest accumulate
    always_ff @(posedge clk_i) begin
        if (step_i.tap_en) begin
            if (step_i.clear) begin
                acc_q <= conv_fixed_pkg::acc_t'(product);
            end else begin
                acc_q <= acc_q + conv_fixed_pkg::acc_t'(product);
            end
        end
    end

    // bias moved up to accumulator scale, then round half up
    assign biased = acc_q
                  + (conv_fixed_pkg::acc_t'(bias_i) <<< conv_fixed_pkg::FRAC_BITS)
                  + conv_fixed_pkg::ROUND_HALF;

    // back to Q4.12 scale, sign preserved
    assign scaled = biased >>> conv_fixed_pkg::FRAC_BITS;

    // clamp into the output word
    always_comb begin
        if (scaled > conv_fixed_pkg::acc_t'(conv_fixed_pkg::WORD_MAX)) begin
            sat = conv_fixed_pkg::WORD_MAX;
        end else if (scaled < conv_fixed_pkg::acc_t'(conv_fixed_pkg::WORD_MIN)) begin
            sat = conv_fixed_pkg::WORD_MIN;
        end else begin
            sat = conv_fixed_pkg::word_t'(scaled);
        end
    end

    // result held until the next run's bias cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q <= '0;
        end else if (step_i.bias_en) begin
            result_q <= sat;
        end
    end

    assign result_o = result_q;

    // bias cycle must follow the last tap, never overlap it
    a_tap_bias_exclusive : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(step_i.tap_en && step_i.bias_en)
    ) else $error("tap_en and bias_en high in the same cycle");

endmodule

//--- project.f
+incdir+bench
design/conv_fixed_pkg.sv
design/conv_layer_pkg.sv
design/conv_coef_regs.sv
design/conv_input_buffer.sv
design/conv_mac_lane.sv
design/conv_layer_ctrl.sv
design/conv_layer_top.sv
bench/conv_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module conv_layer_tb -f project.f

out=$(./obj_dir/Vconv_layer_tb)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
